// ==== Bender.yml ====
package:
  name: icache

sources:
  - common/icachePkg.sv
  - icache/icacheWay.sv
  - icache/icacheLruTable.sv
  - icache/icacheBusMaster.sv
  - icache/icacheController.sv
  - src/icacheTop.sv
  - target: test
    files:
      - tb/ahbMemModel.sv
      - tb/icacheTb.sv

// ==== common/icachePkg.sv ====
// ##########################################################
// Shared cache geometry and controller state encoding.
// Referenced by scoped name from every cache block.
// ##########################################################

package icachePkg;

  // Instruction and bus word width
  localparam int wordBits = 32;

  // Byte offset within a word stays zero on the bus
  localparam int byteBits = 2;

  // Word offset within a line
  localparam int offsetBits = 2;
  localparam int lineWords = 2 ** offsetBits;

  // Set index and number of sets per way
  localparam int setBits = 4;
  localparam int numSets = 2 ** setBits;

  // Tag is whatever is left above set and offsets
  localparam int tagBits = wordBits - setBits - offsetBits - byteBits;

  // Line-aligned part of an address made of tag and set index
  localparam int lineAddrBits = tagBits + setBits;

  // Miss handling states
  // ready      idle or hitting, a miss starts the fill
  // memRead    address phases of the line or single word
  // lastRead   final data phase
  // nextInstr  delivers the fetched word, fetch resumes
  typedef enum logic [1:0] {
    ready     = 2'd0,
    memRead   = 2'd1,
    lastRead  = 2'd2,
    nextInstr = 2'd3
  } cacheState;

endpackage

// ==== icache.f ====
common/icachePkg.sv
icache/icacheWay.sv
icache/icacheLruTable.sv
icache/icacheBusMaster.sv
icache/icacheController.sv
src/icacheTop.sv
tb/ahbMemModel.sv
tb/icacheTb.sv

// ==== icache/icacheBusMaster.sv ====
// ##########################################################
// Bus master for line fills. Single nonsequential reads,
// data phase of one transfer overlaps the next address phase.
// ##########################################################

module icacheBusMaster (
  input  logic                              clk,
  input  logic                              reset,
  input  logic [icachePkg::lineAddrBits-1:0] lineAddr,
  input  logic [icachePkg::offsetBits-1:0]   addrWordOffset,
  input  logic                              busRequest,
  output logic                              busReady,
  output logic [icachePkg::wordBits-1:0]     fillData,
  output logic [icachePkg::wordBits-1:0]     hAddr,
  output logic                              hTrans,
  input  logic                              hReady,
  input  logic [icachePkg::wordBits-1:0]     hRData
);

  logic dataPending;

  // Word-aligned transfer address
  assign hAddr = {lineAddr, addrWordOffset, {icachePkg::byteBits{1'b0}}};
  assign hTrans = busRequest;

  // Set by an accepted address phase, held while the slave waits
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      dataPending <= 1'b0;
    end else if (hReady) begin
      dataPending <= hTrans;
    end
  end

  // Only report progress while a transfer of ours is on the bus
  assign busReady = hReady && (hTrans || dataPending);
  assign fillData = hRData;

endmodule

// ==== icache/icacheController.sv ====
// ##########################################################
// Instruction cache control: hit check, miss FSM, fill
// counter, victim choice and bus word offsets.
// ##########################################################

module icacheController (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            cacheEnable,
  input  logic                            fetchValid,
  input  logic [icachePkg::tagBits-1:0]    fetchTag,
  input  logic [icachePkg::offsetBits-1:0] fetchWordOffset,
  input  logic [icachePkg::tagBits-1:0]    way1Tag,
  input  logic [icachePkg::tagBits-1:0]    way2Tag,
  input  logic                            way1Valid,
  input  logic                            way2Valid,
  input  logic [icachePkg::wordBits-1:0]   way1Data,
  input  logic [icachePkg::wordBits-1:0]   way2Data,
  input  logic                            currLru,
  input  logic                            busReady,
  output logic [icachePkg::wordBits-1:0]   instr,
  output logic                            iStall,
  output logic                            busRequest,
  output logic [icachePkg::offsetBits-1:0] addrWordOffset,
  output logic [icachePkg::offsetBits-1:0] fillWordOffset,
  output logic                            way1We,
  output logic                            way2We,
  output logic                            fillValid,
  output logic                            lruUpdate,
  output logic                            lruWay1Used
);

  icachePkg::cacheState state;
  icachePkg::cacheState nextState;

  logic                            way1Hit;
  logic                            way2Hit;
  logic                            hit;
  logic                            fillWay1;
  logic                            lastAddr;
  logic                            dataPhase;
  logic                            writeEn;
  logic [icachePkg::offsetBits-1:0] fillCount;

  // Tag match per way, qualified by valid
  assign way1Hit = way1Valid && (way1Tag == fetchTag);
  assign way2Hit = way2Valid && (way2Tag == fetchTag);
  assign hit = (way1Hit || way2Hit) && fetchValid && cacheEnable;

  // Victim choice. A way that already holds the tag keeps it,
  // and an uncached fetch always goes through way 1
  assign fillWay1 = !cacheEnable || way1Hit ||
                    (((!way1Valid && way2Valid) || currLru) && !way2Hit);

  // Last address phase of the line, or the single uncached word
  assign lastAddr = (&fillCount) || !cacheEnable;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= icachePkg::ready;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      icachePkg::ready:     if (fetchValid && !hit) nextState = icachePkg::memRead;
      icachePkg::memRead:   if (busReady && lastAddr) nextState = icachePkg::lastRead;
      icachePkg::lastRead:  if (busReady) nextState = icachePkg::nextInstr;
      icachePkg::nextInstr: nextState = icachePkg::ready;
      default:              nextState = icachePkg::ready;
    endcase
  end

  // Accepted transfer counter that starts at the fetched word when uncached
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      fillCount <= '0;
    end else if (state == icachePkg::ready) begin
      fillCount <= cacheEnable ? '0 : fetchWordOffset;
    end else if (busRequest && busReady) begin
      fillCount <= fillCount + 1'b1;
    end
  end

  assign busRequest = (state == icachePkg::memRead);
  assign iStall = ((state == icachePkg::ready) && fetchValid && !hit) ||
                  (state == icachePkg::memRead) || (state == icachePkg::lastRead);

  // Address phase walks the line, otherwise the ways read the fetched word
  assign addrWordOffset = busRequest ? fillCount : fetchWordOffset;
  // Data phase trails the address phase by one transfer
  assign fillWordOffset = fillCount - 1'b1;

  // In memRead a data phase exists once the first line word was accepted
  assign dataPhase = ((state == icachePkg::memRead) && cacheEnable && (fillCount != '0)) ||
                     (state == icachePkg::lastRead);
  assign writeEn = dataPhase && busReady;
  assign way1We = writeEn && fillWay1;
  assign way2We = writeEn && !fillWay1;
  // Uncached words are stored invalid so they never hit
  assign fillValid = cacheEnable;

  // Replacement tracking on hits and at the end of a cached fill
  assign lruUpdate = ((state == icachePkg::ready) && hit) ||
                     ((state == icachePkg::lastRead) && busReady && cacheEnable);
  assign lruWay1Used = fillWay1;

  assign instr = (!cacheEnable || way1Hit) ? way1Data : way2Data;

endmodule

// ==== icache/icacheLruTable.sv ====
// ##########################################################
// Replacement state, one bit per set. High selects way 1 as
// the next victim.
// ##########################################################

module icacheLruTable (
  input  logic                         clk,
  input  logic                         reset,
  input  logic [icachePkg::setBits-1:0] setIndex,
  input  logic                         update,
  input  logic                         way1Used,
  output logic                         currLru
);

  logic [icachePkg::numSets-1:0] lruBits;

  // Point away from the way just used
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      lruBits <= '0;
    end else if (update) begin
      lruBits[setIndex] <= !way1Used;
    end
  end

  assign currLru = lruBits[setIndex];

endmodule

// ==== icache/icacheWay.sv ====
// ##########################################################
// One cache way: per-set tag and valid, four data words per
// line. Combinational read, one word written per clock.
// ##########################################################

module icacheWay (
  input  logic                            clk,
  input  logic                            reset,
  input  logic [icachePkg::setBits-1:0]    setIndex,
  input  logic [icachePkg::offsetBits-1:0] readWordOffset,
  input  logic [icachePkg::offsetBits-1:0] writeWordOffset,
  input  logic                            we,
  input  logic [icachePkg::tagBits-1:0]    writeTag,
  input  logic                            writeValid,
  input  logic [icachePkg::wordBits-1:0]   writeData,
  output logic [icachePkg::tagBits-1:0]    tag,
  output logic                            valid,
  output logic [icachePkg::wordBits-1:0]   data
);

  logic [icachePkg::tagBits-1:0]  tagMem [icachePkg::numSets];
  logic [icachePkg::wordBits-1:0] dataMem [icachePkg::numSets][icachePkg::lineWords];
  logic [icachePkg::numSets-1:0]  validBits;

  // Each fill word also refreshes the set tag
  always_ff @(posedge clk) begin
    if (we) begin
      dataMem[setIndex][writeWordOffset] <= writeData;
      tagMem[setIndex] <= writeTag;
    end
  end

  // Valid bits come up clear so the cache starts empty
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      validBits <= '0;
    end else if (we) begin
      validBits[setIndex] <= writeValid;
    end
  end

  assign tag = tagMem[setIndex];
  assign valid = validBits[setIndex];
  assign data = dataMem[setIndex][readWordOffset];

endmodule

// ==== src/icacheTop.sv ====
// ##########################################################
// Instruction cache top level. Connects the fetch port and
// the memory bus to the controller, ways, LRU and bus master.
// ##########################################################

module icacheTop (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [icachePkg::wordBits-1:0] fetchAddr,
  input  logic                          fetchValid,
  input  logic                          cacheEnable,
  output logic [icachePkg::wordBits-1:0] instr,
  output logic                          iStall,
  output logic [icachePkg::wordBits-1:0] hAddr,
  output logic                          hTrans,
  input  logic                          hReady,
  input  logic [icachePkg::wordBits-1:0] hRData
);

  logic [icachePkg::tagBits-1:0]      fetchTag;
  logic [icachePkg::setBits-1:0]      setIndex;
  logic [icachePkg::offsetBits-1:0]   fetchWordOffset;
  logic [icachePkg::lineAddrBits-1:0] lineAddr;

  logic [icachePkg::tagBits-1:0]      way1Tag;
  logic [icachePkg::tagBits-1:0]      way2Tag;
  logic                              way1Valid;
  logic                              way2Valid;
  logic [icachePkg::wordBits-1:0]     way1Data;
  logic [icachePkg::wordBits-1:0]     way2Data;
  logic                              way1We;
  logic                              way2We;
  logic                              fillValid;
  logic [icachePkg::offsetBits-1:0]   addrWordOffset;
  logic [icachePkg::offsetBits-1:0]   fillWordOffset;

  logic                              currLru;
  logic                              lruUpdate;
  logic                              lruWay1Used;

  logic                              busRequest;
  logic                              busReady;
  logic [icachePkg::wordBits-1:0]     fillData;

  // Address fields of the fetch
  assign fetchTag = fetchAddr[icachePkg::wordBits-1 -: icachePkg::tagBits];
  assign setIndex = fetchAddr[icachePkg::byteBits + icachePkg::offsetBits +: icachePkg::setBits];
  assign fetchWordOffset = fetchAddr[icachePkg::byteBits +: icachePkg::offsetBits];
  assign lineAddr = fetchAddr[icachePkg::wordBits-1 -: icachePkg::lineAddrBits];

  icacheController controller (
    .clk             (clk),
    .reset           (reset),
    .cacheEnable     (cacheEnable),
    .fetchValid      (fetchValid),
    .fetchTag        (fetchTag),
    .fetchWordOffset (fetchWordOffset),
    .way1Tag         (way1Tag),
    .way2Tag         (way2Tag),
    .way1Valid       (way1Valid),
    .way2Valid       (way2Valid),
    .way1Data        (way1Data),
    .way2Data        (way2Data),
    .currLru         (currLru),
    .busReady        (busReady),
    .instr           (instr),
    .iStall          (iStall),
    .busRequest      (busRequest),
    .addrWordOffset  (addrWordOffset),
    .fillWordOffset  (fillWordOffset),
    .way1We          (way1We),
    .way2We          (way2We),
    .fillValid       (fillValid),
    .lruUpdate       (lruUpdate),
    .lruWay1Used     (lruWay1Used)
  );

  icacheWay way1 (
    .clk             (clk),
    .reset           (reset),
    .setIndex        (setIndex),
    .readWordOffset  (addrWordOffset),
    .writeWordOffset (fillWordOffset),
    .we              (way1We),
    .writeTag        (fetchTag),
    .writeValid      (fillValid),
    .writeData       (fillData),
    .tag             (way1Tag),
    .valid           (way1Valid),
    .data            (way1Data)
  );

  icacheWay way2 (
    .clk             (clk),
    .reset           (reset),
    .setIndex        (setIndex),
    .readWordOffset  (addrWordOffset),
    .writeWordOffset (fillWordOffset),
    .we              (way2We),
    .writeTag        (fetchTag),
    .writeValid      (fillValid),
    .writeData       (fillData),
    .tag             (way2Tag),
    .valid           (way2Valid),
    .data            (way2Data)
  );

  icacheLruTable lruTable (
    .clk      (clk),
    .reset    (reset),
    .setIndex (setIndex),
    .update   (lruUpdate),
    .way1Used (lruWay1Used),
    .currLru  (currLru)
  );

  icacheBusMaster busMaster (
    .clk            (clk),
    .reset          (reset),
    .lineAddr       (lineAddr),
    .addrWordOffset (addrWordOffset),
    .busRequest     (busRequest),
    .busReady       (busReady),
    .fillData       (fillData),
    .hAddr          (hAddr),
    .hTrans         (hTrans),
    .hReady         (hReady),
    .hRData         (hRData)
  );

endmodule

// ==== tb/ahbMemModel.sv ====
// ##########################################################
// Bus slave model for the cache testbench. Read-only memory
// whose words follow from the address, random wait states.
// ##########################################################

module ahbMemModel (
  input  logic        clk,
  input  logic        reset,
  input  logic [31:0] hAddr,
  input  logic        hTrans,
  output logic        hReady,
  output logic [31:0] hRData
);

  logic [31:0] lcgState;
  logic [31:0] lcgDraw;
  logic        pending;
  logic [31:0] pendAddr;
  logic [1:0]  waitLeft;

  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Memory word is the address scrambled then rotated left by 7
  function automatic logic [31:0] wordAt(input logic [31:0] addr);
    logic [31:0] x;
    x = addr ^ 32'h5a3c96e1;
    return {x[24:0], x[31:25]};
  endfunction

  // 0 to 2 wait states from the upper LCG bits
  function automatic logic [1:0] waitStates(input logic [31:0] s);
    logic [15:0] r;
    r = s[31:16] % 16'd3;
    return r[1:0];
  endfunction

  assign lcgDraw = lcgNext(lcgState);
  assign hReady = !pending || (waitLeft == 2'd0);
  assign hRData = pending ? wordAt(pendAddr) : 32'h0;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      lcgState <= 32'hf8810dbe;
      pending <= 1'b0;
      pendAddr <= 32'h0;
      waitLeft <= 2'd0;
    end else if (hReady) begin
      // Previous data phase done, accept the next address phase
      pending <= hTrans;
      pendAddr <= hAddr;
      if (hTrans) begin
        lcgState <= lcgDraw;
        waitLeft <= waitStates(lcgDraw);
      end
    end else begin
      waitLeft <= waitLeft - 2'd1;
    end
  end

endmodule

// ==== tb/icacheTb.sv ====
// ##########################################################
// Testbench for the instruction cache. Runs a fetch table
// against a bus memory model and checks words and transfers.
// ##########################################################

module icacheTb;

  localparam int numEntries = 22;
  localparam int cyclesPerEntry = 40;
  localparam int resetCycles = 10;
  localparam int clkPeriod = 10;
  localparam int watchdogTime = (resetCycles + numEntries * cyclesPerEntry) * clkPeriod;

  logic        clk;
  logic        reset;
  logic [31:0] fetchAddr;
  logic        fetchValid;
  logic        cacheEnable;
  logic [31:0] instr;
  logic        iStall;
  logic [31:0] hAddr;
  logic        hTrans;
  logic        hReady;
  logic [31:0] hRData;

  // Stimulus table of fetch address, cache enable and expected hit
  logic [31:0] tableAddr [numEntries];
  logic        tableEnable [numEntries];
  logic        tableHit [numEntries];
  int          loadIndex;

  int errorCount;
  int passCount;
  int failCount;

  icacheTop icacheTop_i (
    .clk         (clk),
    .reset       (reset),
    .fetchAddr   (fetchAddr),
    .fetchValid  (fetchValid),
    .cacheEnable (cacheEnable),
    .instr       (instr),
    .iStall      (iStall),
    .hAddr       (hAddr),
    .hTrans      (hTrans),
    .hReady      (hReady),
    .hRData      (hRData)
  );

  ahbMemModel memModel (
    .clk    (clk),
    .reset  (reset),
    .hAddr  (hAddr),
    .hTrans (hTrans),
    .hReady (hReady),
    .hRData (hRData)
  );

  always #(clkPeriod / 2) clk = !clk;

  // Word the memory holds at a given address
  function automatic logic [31:0] expectedWord(input logic [31:0] addr);
    logic [31:0] x;
    x = addr ^ 32'h5a3c96e1;
    return {x[24:0], x[31:25]};
  endfunction

  task automatic addEntry(input logic [31:0] addr, input logic enable, input logic hit);
    tableAddr[loadIndex] = addr;
    tableEnable[loadIndex] = enable;
    tableHit[loadIndex] = hit;
    loadIndex++;
  endtask

  task automatic loadTable();
    loadIndex = 0;
    // Line A fills set 3, then its other words hit
    addEntry(32'h00001230, 1'b1, 1'b0);
    addEntry(32'h00001234, 1'b1, 1'b1);
    addEntry(32'h00001238, 1'b1, 1'b1);
    addEntry(32'h0000123c, 1'b1, 1'b1);
    // Line B shares set 3 and hits alternate between A and B
    addEntry(32'h00005630, 1'b1, 1'b0);
    addEntry(32'h00001234, 1'b1, 1'b1);
    addEntry(32'h00005638, 1'b1, 1'b1);
    addEntry(32'h0000123c, 1'b1, 1'b1);
    addEntry(32'h00005634, 1'b1, 1'b1);
    // Line C evicts A as the least recently used
    addEntry(32'h00009a30, 1'b1, 1'b0);
    addEntry(32'h0000563c, 1'b1, 1'b1);
    addEntry(32'h00001238, 1'b1, 1'b0);
    addEntry(32'h00005630, 1'b1, 1'b1);
    // Uncached fetches including one to the resident line B
    addEntry(32'h00007744, 1'b0, 1'b0);
    addEntry(32'h00007748, 1'b0, 1'b0);
    addEntry(32'h00005634, 1'b0, 1'b0);
    addEntry(32'h00007744, 1'b1, 1'b0);
    addEntry(32'h00005634, 1'b1, 1'b0);
    addEntry(32'h0000774c, 1'b1, 1'b1);
    addEntry(32'h0000123c, 1'b1, 1'b1);
    addEntry(32'hffffff0c, 1'b1, 1'b0);
    addEntry(32'hffffff00, 1'b1, 1'b1);
  endtask

  task automatic checkResetState();
    @(negedge clk);
    if (iStall !== 1'b0) begin
      $display("Mismatch iStall: got %h expected %h", iStall, 1'b0);
      errorCount++;
    end
    if (hTrans !== 1'b0) begin
      $display("Mismatch hTrans: got %h expected %h", hTrans, 1'b0);
      errorCount++;
    end
    if (errorCount == 0) begin
      passCount++;
      $display("Reset state: ok");
    end else begin
      failCount++;
      $display("Reset state: failed");
    end
  endtask

  task automatic runEntry(input int idx);
    int          transfers;
    int          expTransfers;
    int          errorsBefore;
    logic [31:0] expWord;
    errorsBefore = errorCount;
    transfers = 0;
    @(posedge clk);
    #1;
    fetchAddr = tableAddr[idx];
    cacheEnable = tableEnable[idx];
    fetchValid = 1'b1;
    // Count accepted address phases until the fetch completes
    do begin
      @(negedge clk);
      if (hTrans && hReady) begin
        transfers++;
        if (!cacheEnable && hAddr !== fetchAddr) begin
          $display("Mismatch hAddr: got %h expected %h", hAddr, fetchAddr);
          errorCount++;
        end
        if (cacheEnable && hAddr[31:4] !== fetchAddr[31:4]) begin
          $display("Transfer at %h lies outside the line of fetch %h", hAddr, fetchAddr);
          errorCount++;
        end
      end
    end while (iStall);
    if (!tableEnable[idx]) begin
      expTransfers = 1;
    end else if (tableHit[idx]) begin
      expTransfers = 0;
    end else begin
      expTransfers = 4;
    end
    if (transfers != expTransfers) begin
      $display("Mismatch transfers: got %h expected %h", transfers, expTransfers);
      errorCount++;
    end
    expWord = expectedWord(tableAddr[idx]);
    if (instr !== expWord) begin
      $display("Mismatch instr: got %h expected %h", instr, expWord);
      errorCount++;
    end
    if (errorCount == errorsBefore) begin
      passCount++;
      $display("Entry %0d addr %h enable %0d: ok", idx, tableAddr[idx], tableEnable[idx]);
    end else begin
      failCount++;
      $display("Entry %0d addr %h enable %0d: failed", idx, tableAddr[idx], tableEnable[idx]);
    end
  endtask

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    fetchAddr = 32'h0;
    fetchValid = 1'b0;
    cacheEnable = 1'b1;
    errorCount = 0;
    passCount = 0;
    failCount = 0;
    loadTable();
    repeat (resetCycles) @(posedge clk);
    #1;
    reset = 1'b0;
    checkResetState();
    for (int i = 0; i < numEntries; i++) begin
      runEntry(i);
    end
    @(posedge clk);
    #1;
    fetchValid = 1'b0;
    $display("Tests: %0d passed, %0d failed", passCount, failCount);
    if (failCount == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // Watchdog sized from the table length
  initial begin
    #(watchdogTime);
    $display("Watchdog expired, a fetch never completed");
    $display("Regression failed");
    $finish;
  end

endmodule
